//--- tb_input.txt
// mask rw addr wdata exp_rdata exp_timeout, all hex
// mask picks masters started together, rw 1 is a read, last row of zeros ends the list
1 1 3000 00 03 0
1 1 4000 00 04 0
1 0 3010 5a 00 0
1 1 3010 00 5a 0
2 0 4010 c3 00 0
2 1 4010 00 c3 0
4 1 3010 00 5a 0
4 0 5020 11 00 1
1 1 6020 00 00 1
1 1 3010 00 5a 0
3 0 3abc 7f 00 0
3 1 3abc 00 7f 0
6 1 4010 00 c3 0
7 1 3fff 00 00 0
5 0 4fff ff 00 0
1 1 4fff 00 ff 0
2 1 4000 00 04 0
0 0 0000 00 00 0

//--- project.f
bus_pkg.sv
host_pkg.sv
bus_controller.sv
bus_master.sv
memory_slave.sv
read_display.sv
bus_top.sv
bus_top_sva.sv
tb_bus_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bus testbench with Verilator, pass decided from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_top \
    -f project.f -o tb_bus_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bus_top +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1

//--- tb_bus_top.sv
`timescale 1ns/1ns

module tb_bus_top import bus_pkg::*, host_pkg::*;;

    localparam int CLK_PERIOD     = 10;
    localparam int RST_CYCLES     = 4;
    localparam int COLS           = 6;
    localparam int MAX_VEC        = 64;
    localparam int NUM_RAND       = 4;
    localparam int CYCLES_PER_VEC = 60;
    // quiet cycles watched after an ignored execute
    localparam int QUIET_CYCLES   = 40;

    logic                   clk = 1'b0;
    logic                   rst;
    host_cmd_t              cmd [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] execute;
    logic [NUM_MASTERS-1:0] busy;
    host_rsp_t              rsp [NUM_MASTERS];
    master_id_t             current_master;
    logic                   utilization;
    logic [11:0]            bcd;

    // one vector is COLS words, see tb_input.txt
    logic [15:0] vec_mem [COLS*MAX_VEC];
    int          n_vec;
    int          cycle_cnt = 0;
    int          budget_cycles;
    logic        armed = 1'b0;

    // what each master returned on its last done
    int          done_cycle [NUM_MASTERS];
    data_t       got_rdata [NUM_MASTERS];
    logic        got_to [NUM_MASTERS];

    bus_top uut (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd),
        .execute        (execute),
        .busy           (busy),
        .rsp            (rsp),
        .current_master (current_master),
        .utilization    (utilization),
        .bcd            (bcd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, exp));
        end
    endtask

    // decimal digits, hundreds first
    function automatic logic [11:0] to_bcd(input data_t v);
        int h;
        int t;
        int u;
        h = v / 100;
        t = (v / 10) % 10;
        u = v % 10;
        return {h[3:0], t[3:0], u[3:0]};
    endfunction

    // same command to every master in mask, execute held for one cycle
    task automatic start_cmd(input logic [NUM_MASTERS-1:0] mask, input logic rw,
                             input addr_t addr, input data_t wdata);
        @(posedge clk);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (mask[i]) begin
                cmd[i] <= '{rw: rw, addr: addr, wdata: wdata};
            end
        end
        execute <= mask;
        @(posedge clk);
        execute <= '0;
    endtask

    task automatic wait_dones(input logic [NUM_MASTERS-1:0] mask);
        logic [NUM_MASTERS-1:0] pending;
        pending = mask;
        while (pending != '0) begin
            @(negedge clk);
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (rsp[i].done) begin
                    if (!pending[i]) begin
                        fail_run($sformatf("master %0d signalled done with nothing pending", i));
                    end
                    // finishing master still owns the bus during done
                    check_value("current_master", current_master, i);
                    pending[i]    = 1'b0;
                    done_cycle[i] = cycle_cnt;
                    got_rdata[i]  = rsp[i].rdata;
                    got_to[i]     = rsp[i].timeout;
                end
            end
        end
    endtask

    task automatic run_transfer(input logic [NUM_MASTERS-1:0] mask, input logic rw,
                                input addr_t addr, input data_t wdata,
                                input data_t exp_rdata, input logic exp_to);
        start_cmd(mask, rw, addr, wdata);
        wait_dones(mask);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (mask[i]) begin
                check_value($sformatf("rsp[%0d].timeout", i), got_to[i], exp_to);
                if (rw && !exp_to) begin
                    check_value($sformatf("rsp[%0d].rdata", i), got_rdata[i], exp_rdata);
                end
                // lower index owns the bus first
                for (int j = i + 1; j < NUM_MASTERS; j++) begin
                    if (mask[j]) begin
                        check_value($sformatf("done order %0d before %0d", i, j),
                                    done_cycle[i] < done_cycle[j], 1);
                    end
                end
            end
        end
        // display takes one more cycle, bus must be free by now
        @(negedge clk);
        check_value("utilization", utilization, 0);
        check_value("busy", busy, 0);
        if (rw && !exp_to) begin
            check_value("bcd", bcd, to_bcd(exp_rdata));
        end
    endtask

    // second execute during a read must not start anything
    task automatic ignored_execute_check();
        start_cmd(3'b001, 1'b1, 15'h3010, 8'h00);
        @(negedge clk);
        check_value("busy[0]", busy[0], 1);
        start_cmd(3'b001, 1'b0, 15'h3010, 8'h00);
        wait_dones(3'b001);
        check_value("rsp[0].timeout", got_to[0], 0);
        check_value("rsp[0].rdata", got_rdata[0], 8'h5a);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (rsp[0].done) begin
                fail_run("a second done followed an execute given while busy");
            end
        end
        // memory untouched by the dropped write
        run_transfer(3'b001, 1'b1, 15'h3010, 8'h00, 8'h5a, 1'b0);
    endtask

    // bounds the run by the number of transfers
    initial begin
        wait (armed);
        repeat (budget_cycles) @(posedge clk);
        fail_run("watchdog expired before all transfers completed");
    end

    initial begin
        integer                 seed;
        int                     r;
        addr_t                  addr;
        data_t                  wd;
        logic [NUM_MASTERS-1:0] wr_mask;
        logic [NUM_MASTERS-1:0] rd_mask;
        rst     = 1'b1;
        execute = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            cmd[i] = '0;
        end
        seed = 32'hcf35f054;
        $readmemh("tb_input.txt", vec_mem);
        n_vec = 0;
        // all zero row ends the list
        while (n_vec < MAX_VEC && vec_mem[COLS*n_vec] != 16'd0) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            fail_run("no vectors found in tb_input.txt");
        end
        budget_cycles = RST_CYCLES + (n_vec + 2 * NUM_RAND + 3) * CYCLES_PER_VEC;
        armed = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < n_vec; k++) begin
            run_transfer(vec_mem[COLS*k][NUM_MASTERS-1:0], vec_mem[COLS*k+1][0],
                         vec_mem[COLS*k+2][FRAME_ADDR_BITS-1:0], vec_mem[COLS*k+3][7:0],
                         vec_mem[COLS*k+4][7:0], vec_mem[COLS*k+5][0]);
        end

        ignored_execute_check();

        // random data, write by one master, read back by another
        for (int k = 0; k < NUM_RAND; k++) begin
            r       = $random(seed);
            wd      = r[7:0];
            addr    = {(r[8] ? SLAVE_B_ID : SLAVE_A_ID), 12'h800 + 12'(k)};
            wr_mask = 3'b001 << (r[10:9] % 3);
            rd_mask = 3'b001 << ((r[10:9] + 1) % 3);
            run_transfer(wr_mask, 1'b0, addr, wd, 8'h00, 1'b0);
            run_transfer(rd_mask, 1'b1, addr, 8'h00, wd, 1'b0);
        end

        if (uut.bus_ctrl.sva_chk.fail_cnt == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("bus protocol assertions fired during the run");
        end
    end

endmodule

//--- bus_top_sva.sv
`timescale 1ns/1ns

module bus_top_sva import bus_pkg::*, host_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic [NUM_MASTERS-1:0] grant,
    input bus_down_t              master_down [NUM_MASTERS],
    input bus_up_t                slave_up [NUM_SLAVES],
    input logic [NUM_SLAVES-1:0]  sel
);

    // failures seen so far
    int unsigned            fail_cnt = 0;
    logic [NUM_MASTERS-1:0] util_vec;
    logic [NUM_SLAVES-1:0]  ready_vec;

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            util_vec[i] = master_down[i].util;
        end
    end

    // ready straight from each slave, before the controller gating
    always_comb begin
        for (int j = 0; j < NUM_SLAVES; j++) begin
            ready_vec[j] = slave_up[j].ready;
        end
    end

    // at most one owner
    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("grant not one-hot: %b", grant);
        end

    // only the owner may drive util
    util_owner: assert property (@(posedge clk) disable iff (rst) (util_vec & ~grant) == '0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("util %b without grant %b", util_vec, grant);
        end

    sel_single: assert property (@(posedge clk) disable iff (rst) !(&sel))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("both slaves selected");
        end

    // a slave only answers while it is selected
    ready_sel: assert property (@(posedge clk) disable iff (rst) (ready_vec & ~sel) == '0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ready %b from a slave outside sel %b", ready_vec, sel);
        end

endmodule

bind bus_controller bus_top_sva sva_chk (
    .clk         (clk),
    .rst         (rst),
    .grant       (grant),
    .master_down (master_down),
    .slave_up    (slave_up),
    .sel         (sel)
);

//--- bus_top.sv
`timescale 1ns/1ns

module bus_top import bus_pkg::*, host_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  host_cmd_t              cmd [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] execute,
    output logic [NUM_MASTERS-1:0] busy,
    output host_rsp_t              rsp [NUM_MASTERS],
    output master_id_t             current_master,
    output logic                   utilization,
    output logic [11:0]            bcd
);

    logic [NUM_MASTERS-1:0] req;
    logic [NUM_MASTERS-1:0] grant;
    bus_down_t              master_down [NUM_MASTERS];
    bus_down_t              bus_down;
    bus_up_t                slave_up [NUM_SLAVES];
    bus_up_t                bus_up;
    logic [NUM_SLAVES-1:0]  sel;

    // masters, index 0 has top priority
    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
        bus_master master (
            .clk     (clk),
            .rst     (rst),
            .cmd     (cmd[i]),
            .execute (execute[i]),
            .busy    (busy[i]),
            .rsp     (rsp[i]),
            .req     (req[i]),
            .grant   (grant[i]),
            .down    (master_down[i]),
            .up      (bus_up)
        );
    end

    bus_controller bus_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .grant          (grant),
        .master_down    (master_down),
        .bus_down       (bus_down),
        .slave_up       (slave_up),
        .bus_up         (bus_up),
        .sel            (sel),
        .current_master (current_master),
        .utilization    (utilization)
    );

    // sel bit 0 is slave 3, bit 1 is slave 4
    memory_slave #(.self_id(SLAVE_A_ID)) slave_3 (
        .clk  (clk),
        .rst  (rst),
        .sel  (sel[0]),
        .down (bus_down),
        .up   (slave_up[0])
    );

    memory_slave #(.self_id(SLAVE_B_ID)) slave_4 (
        .clk  (clk),
        .rst  (rst),
        .sel  (sel[1]),
        .down (bus_down),
        .up   (slave_up[1])
    );

    read_display display (
        .clk (clk),
        .rst (rst),
        .rsp (rsp),
        .bcd (bcd)
    );

endmodule

//--- read_display.sv
`timescale 1ns/1ns

module read_display import bus_pkg::*, host_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_rsp_t rsp [NUM_MASTERS],
    output logic [11:0] bcd
);

    data_t       shown_q;
    // bcd digits on top, binary shifted out below
    logic [19:0] dd;

    // lowest index written last so it wins
    always_ff @(posedge clk) begin
        if (rst) begin
            shown_q <= '0;
        end else begin
            for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
                if (rsp[i].done && !rsp[i].timeout) shown_q <= rsp[i].rdata;
            end
        end
    end

    // double dabble, add 3 to any digit above 4 before each shift
    always_comb begin
        dd = {12'd0, shown_q};
        for (int i = 0; i < DATA_BITS; i++) begin
            if (dd[11:8] > 4'd4) dd[11:8] = dd[11:8] + 4'd3;
            if (dd[15:12] > 4'd4) dd[15:12] = dd[15:12] + 4'd3;
            if (dd[19:16] > 4'd4) dd[19:16] = dd[19:16] + 4'd3;
            dd = dd << 1;
        end
        bcd = dd[19:8];
    end

endmodule

//--- memory_slave.sv
`timescale 1ns/1ns

module memory_slave import bus_pkg::*; #(
    parameter slave_id_t self_id = SLAVE_A_ID
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      sel,
    input  bus_down_t down,
    output bus_up_t   up
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_WDATA,
        S_READ,
        S_END
    } s_state_t;

    s_state_t              state_q;
    data_t                 mem [MEM_DEPTH];
    logic [HDR_BITS-2:0]   hdr_q;
    logic [HDR_BITS-1:0]   hdr_next;
    logic [4:0]            bit_cnt_q;
    offset_t               offset_q;
    logic [DATA_BITS-2:0]  wd_q;
    data_t                 rd_q;
    logic                  ready_q;
    logic                  hdr_last;
    logic                  wr_last;

    // location 0 identifies the slave
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
        mem[0] = data_t'(self_id);
    end

    assign hdr_next = {hdr_q, down.sdata};
    assign hdr_last = (state_q == S_HDR) && down.util && (bit_cnt_q == 5'(HDR_BITS - 1));
    assign wr_last  = (state_q == S_WDATA) && down.util && (bit_cnt_q == 5'(DATA_BITS - 1));
    assign up       = '{sdata: rd_q[DATA_BITS-1], ready: ready_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= S_IDLE;
            bit_cnt_q <= '0;
            ready_q   <= 1'b0;
        end else begin
            case (state_q)
                // rw bit arrives with util
                S_IDLE: begin
                    bit_cnt_q <= 5'd1;
                    if (down.util) state_q <= S_HDR;
                end
                S_HDR: begin
                    bit_cnt_q <= hdr_last ? 5'd0 : bit_cnt_q + 5'd1;
                    if (!down.util) begin
                        state_q <= S_IDLE;
                    end else if (hdr_last) begin
                        // reads answer only when selected
                        ready_q <= hdr_next[HDR_BITS-1] && sel;
                        if (!hdr_next[HDR_BITS-1]) state_q <= S_WDATA;
                        else state_q <= sel ? S_READ : S_END;
                    end
                end
                S_WDATA: begin
                    bit_cnt_q <= bit_cnt_q + 5'd1;
                    if (!down.util) state_q <= S_IDLE;
                    if (wr_last) begin
                        // single ready pulse acks the write
                        ready_q <= sel;
                        state_q <= S_END;
                    end
                end
                S_READ: begin
                    bit_cnt_q <= bit_cnt_q + 5'd1;
                    if (bit_cnt_q == 5'(DATA_BITS - 1)) begin
                        ready_q <= 1'b0;
                        state_q <= S_END;
                    end
                end
                S_END: begin
                    ready_q <= 1'b0;
                    if (!down.util) state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // header, write data and read word shifting
    always_ff @(posedge clk) begin
        hdr_q <= hdr_next[HDR_BITS-2:0];
        if (hdr_last) begin
            offset_q <= hdr_next[OFFSET_BITS-1:0];
            rd_q     <= mem[hdr_next[OFFSET_BITS-1:0]];
        end else if (state_q == S_READ) begin
            rd_q <= rd_q << 1;
        end
        if (state_q == S_WDATA) wd_q <= hdr_next[DATA_BITS-2:0];
        if (wr_last && sel) mem[offset_q] <= {wd_q, down.sdata};
    end

endmodule

//--- bus_master.sv
`timescale 1ns/1ns

module bus_master import bus_pkg::*, host_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_cmd_t cmd,
    input  logic      execute,
    output logic      busy,
    output host_rsp_t rsp,
    output logic      req,
    input  logic      grant,
    output bus_down_t down,
    input  bus_up_t   up
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_REQ,
        M_HDR,
        M_DATA,
        M_WAIT,
        M_RECV,
        M_DONE
    } m_state_t;

    m_state_t                        state_q;
    logic                            req_q;
    logic                            util_q;
    logic                            rw_q;
    logic                            timeout_q;
    // outgoing frame, MSB on the line
    logic [FRAME_BITS-1:0]           frame_q;
    logic [4:0]                      bit_cnt_q;
    // cycles since the last frame bit or ready
    logic [$clog2(TIMEOUT_LEN)-1:0]  to_cnt_q;
    data_t                           rx_q;
    // keeps the last word read by this master
    data_t                           rdata_q;
    logic                            rx_last;
    logic                            to_expire;

    assign busy = (state_q != M_IDLE);
    assign req  = req_q;
    assign down = '{util: util_q, sdata: frame_q[FRAME_BITS-1]};
    assign rsp  = '{done: (state_q == M_DONE), timeout: timeout_q, rdata: rdata_q};

    assign rx_last   = (state_q == M_RECV) && up.ready && (bit_cnt_q == 5'(DATA_BITS - 1));
    assign to_expire = !up.ready && (to_cnt_q == ($clog2(TIMEOUT_LEN))'(TIMEOUT_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= M_IDLE;
            req_q     <= 1'b0;
            util_q    <= 1'b0;
            timeout_q <= 1'b0;
            bit_cnt_q <= '0;
            to_cnt_q  <= '0;
            rdata_q   <= '0;
        end else begin
            case (state_q)
                M_IDLE: begin
                    if (execute) begin
                        req_q     <= 1'b1;
                        timeout_q <= 1'b0;
                        state_q   <= M_REQ;
                    end
                end
                M_REQ: begin
                    // frame starts the cycle after the grant is seen
                    if (grant) begin
                        util_q    <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= M_HDR;
                    end
                end
                M_HDR, M_DATA: begin
                    bit_cnt_q <= bit_cnt_q + 5'd1;
                    to_cnt_q  <= 1;
                    if (state_q == M_HDR && bit_cnt_q == 5'(HDR_BITS - 1)) begin
                        state_q <= rw_q ? M_WAIT : M_DATA;
                    end else if (bit_cnt_q == 5'(FRAME_BITS - 1)) begin
                        state_q <= M_WAIT;
                    end
                end
                M_WAIT, M_RECV: begin
                    if (up.ready) begin
                        to_cnt_q <= 1;
                    end else begin
                        to_cnt_q <= to_cnt_q + 1'b1;
                    end
                    if (state_q == M_WAIT && up.ready) begin
                        // write ack ends it, read data starts here
                        bit_cnt_q <= 5'd1;
                        state_q   <= rw_q ? M_RECV : M_DONE;
                        util_q    <= rw_q;
                        req_q     <= rw_q;
                    end else if (state_q == M_RECV && up.ready) begin
                        bit_cnt_q <= bit_cnt_q + 5'd1;
                    end
                    if (rx_last) begin
                        rdata_q <= {rx_q[DATA_BITS-2:0], up.sdata};
                        util_q  <= 1'b0;
                        req_q   <= 1'b0;
                        state_q <= M_DONE;
                    end else if (to_expire) begin
                        timeout_q <= 1'b1;
                        util_q    <= 1'b0;
                        req_q     <= 1'b0;
                        state_q   <= M_DONE;
                    end
                end
                M_DONE: state_q <= M_IDLE;
                default: state_q <= M_IDLE;
            endcase
        end
    end

    // frame and read shift registers
    always_ff @(posedge clk) begin
        if (state_q == M_IDLE && execute) begin
            rw_q    <= cmd.rw;
            frame_q <= {cmd.rw, cmd.addr, cmd.wdata};
        end else if (state_q == M_HDR || state_q == M_DATA) begin
            frame_q <= frame_q << 1;
        end
        if ((state_q == M_WAIT || state_q == M_RECV) && up.ready) begin
            rx_q <= {rx_q[DATA_BITS-2:0], up.sdata};
        end
    end

endmodule

//--- bus_controller.sv
`timescale 1ns/1ns

module bus_controller import bus_pkg::*, host_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_MASTERS-1:0] req,
    output logic [NUM_MASTERS-1:0] grant,
    input  bus_down_t              master_down [NUM_MASTERS],
    output bus_down_t              bus_down,
    input  bus_up_t                slave_up [NUM_SLAVES],
    output bus_up_t                bus_up,
    output logic [NUM_SLAVES-1:0]  sel,
    output master_id_t             current_master,
    output logic                   utilization
);

    logic [NUM_MASTERS-1:0] pick;
    master_id_t             pick_id;
    // granted master has started its frame
    logic                   active_q;
    // frame bits seen, saturates once the id is in
    logic [2:0]             bit_cnt_q;
    slave_id_t              id_q;
    logic [NUM_SLAVES-1:0]  id_match;

    // fixed priority, lowest index wins
    always_comb begin
        pick    = '0;
        pick_id = '0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
                pick_id = master_id_t'(i);
            end
        end
    end

    // registered grant, held while the owner keeps util high
    always_ff @(posedge clk) begin
        if (rst) begin
            grant          <= '0;
            current_master <= '0;
            active_q       <= 1'b0;
        end else if (grant == '0) begin
            grant          <= pick;
            current_master <= pick_id;
            active_q       <= 1'b0;
        end else if (!active_q) begin
            // owner takes a cycle to react to its grant
            active_q <= bus_down.util;
        end else if (!bus_down.util) begin
            grant    <= '0;
            active_q <= 1'b0;
        end
    end

    // granted master onto the shared line
    always_comb begin
        bus_down = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (grant[i]) begin
                bus_down = master_down[i];
            end
        end
    end

    assign utilization = bus_down.util;

    // slave id sits in frame bits 1 to 3, right behind rw
    assign id_match[0] = (id_q == SLAVE_A_ID);
    assign id_match[1] = (id_q == SLAVE_B_ID);

    always_ff @(posedge clk) begin
        if (rst || !bus_down.util) begin
            bit_cnt_q <= '0;
            id_q      <= '0;
            sel       <= '0;
        end else begin
            if (bit_cnt_q != 3'd4) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            if (bit_cnt_q != 3'd0 && bit_cnt_q != 3'd4) begin
                id_q <= {id_q[SLAVE_ID_BITS-2:0], bus_down.sdata};
            end
            // id complete, select until util drops
            if (bit_cnt_q == 3'd4) begin
                sel <= id_match;
            end
        end
    end

    // replies only from selected slaves
    always_comb begin
        bus_up = '0;
        for (int j = 0; j < NUM_SLAVES; j++) begin
            if (sel[j]) begin
                bus_up = bus_up_t'(bus_up | slave_up[j]);
            end
        end
    end

endmodule

//--- host_pkg.sv
package host_pkg;

    // masters competing for the bus
    localparam int NUM_MASTERS = 3;

    typedef logic [1:0] master_id_t;

    // command from the host side
    // rw = 1 is a read
    typedef struct packed {
        logic           rw;
        bus_pkg::addr_t addr;
        bus_pkg::data_t wdata;
    } host_cmd_t;

    // response back to the host
    // done is a single cycle pulse
    // timeout set when no slave answered
    typedef struct packed {
        logic           done;
        logic           timeout;
        bus_pkg::data_t rdata;
    } host_rsp_t;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // serial word sizes
    localparam int DATA_BITS       = 8;
    localparam int FRAME_ADDR_BITS = 15;
    localparam int SLAVE_ID_BITS   = 3;
    localparam int OFFSET_BITS     = 12;

    // rw bit plus address, then write data
    localparam int HDR_BITS   = 1 + FRAME_ADDR_BITS;
    localparam int FRAME_BITS = HDR_BITS + DATA_BITS;

    // slaves present on the bus
    localparam int NUM_SLAVES = 2;
    localparam int MEM_DEPTH  = 2 ** OFFSET_BITS;

    // cycles a master waits for ready
    localparam int TIMEOUT_LEN = 6;

    typedef logic [DATA_BITS-1:0]       data_t;
    typedef logic [FRAME_ADDR_BITS-1:0] addr_t;
    typedef logic [SLAVE_ID_BITS-1:0]   slave_id_t;
    typedef logic [OFFSET_BITS-1:0]     offset_t;

    localparam slave_id_t SLAVE_A_ID = 3'd3;
    localparam slave_id_t SLAVE_B_ID = 3'd4;

    // granted master towards slaves, util spans the whole transfer
    typedef struct packed {
        logic util;
        logic sdata;
    } bus_down_t;

    // selected slave back to the masters
    typedef struct packed {
        logic sdata;
        logic ready;
    } bus_up_t;

endpackage
